/* build.f */
+incdir+common
common/rcc_vdd_pkg.sv
rcc_vdd_reg/rcc_vdd_rsr.sv
rcc_vdd_reg/rcc_vdd_reg.sv
hdl/rcc_vdd_dft_sig_loopback.sv
hdl/rcc_vdd_top.sv
sim/tb_rcc_vdd.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_rcc_vdd -f build.f
./obj_dir/Vtb_rcc_vdd > sim.log 2>&1 || true
cat sim.log
if grep -q "\*\*\* TEST FAILED \*\*\*" sim.log; then
  echo "simulation failed"
  exit 1
fi
if ! grep -q "\*\*\* TEST PASSED \*\*\*" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
echo "simulation passed"

/* sim/tb_rcc_vdd.sv */
`default_nettype none

`include "rcc_vdd_config.svh"

module tb_rcc_vdd;

  // ========================================
  // run length
  // ========================================
  localparam int reset_cycles   = 7;        // reset plus idle check
  localparam int pass_cycles    = 30;       // random pass-through
  localparam int event_cycles   = 14 * 12;  // one pulse and clear per source
  localparam int removal_cycles = 20;
  localparam int csr_cycles     = 12;
  localparam int loop_cycles    = 72;
  localparam int total_cycles   = reset_cycles + pass_cycles + event_cycles +
                                  removal_cycles + csr_cycles + loop_cycles;

  // bit positions in the reset status word, msb first
  localparam int ix_lpwr2 = 14, ix_lpwr1 = 13, ix_wwdg2 = 12, ix_wwdg1 = 11;
  localparam int ix_iwdg2 = 10, ix_iwdg1 = 9, ix_sft2 = 8, ix_sft1 = 7, ix_por = 6;
  localparam int ix_pin = 5, ix_bor = 4, ix_d2 = 3, ix_d1 = 2, ix_obl = 1, ix_rmv = 0;

  logic                       clk;
  logic                       rst;
  logic                       testmode;
  logic                       reg_wr;
  logic [`RCC_VDD_ADDR_W-1:0] reg_addr;
  logic [12:0]                func_drv;   // wdata at 12, then nrst down to d1 at 0
  logic                       iwdg1_rst;
  logic                       iwdg2_rst;
  wire  [`RCC_VDD_RSR_W-1:0]  c1_rsr;
  wire  [`RCC_VDD_RSR_W-1:0]  c2_rsr;
  wire                        csr_lsion;
  wire  [12:0]                gen_vec;    // same order as func_drv
  logic [12:0]                exp_gen;
  logic [`RCC_VDD_RSR_W-1:0]  m_c1;       // model of core 1 word
  logic [`RCC_VDD_RSR_W-1:0]  m_c2;       // model of core 2 word
  logic                       m_lsion;
  logic [13:0]                m_prev;     // model edge samples
  logic [15:0]                lfsr;
  string                      test_name;

  rcc_vdd_top DUT (
    .clk (clk), .rst (rst), .testmode (testmode), .reg_wr (reg_wr), .reg_addr (reg_addr),
    .func_rcc_vdd_wdata (func_drv[12]), .func_nrst_in (func_drv[11]),
    .func_obl_rst (func_drv[10]), .func_lpwr2_rst (func_drv[9]),
    .func_lpwr1_rst (func_drv[8]), .func_wwdg1_out_rst (func_drv[7]),
    .func_wwdg2_out_rst (func_drv[6]), .func_cpu2_sftrst (func_drv[5]),
    .func_cpu1_sftrst (func_drv[4]), .func_pwr_por_rst (func_drv[3]),
    .func_pwr_bor_rst (func_drv[2]), .func_d2_rst (func_drv[1]), .func_d1_rst (func_drv[0]),
    .iwdg1_rst (iwdg1_rst), .iwdg2_rst (iwdg2_rst),
    .c1_rsr (c1_rsr), .c2_rsr (c2_rsr), .csr_lsion (csr_lsion),
    .gen_rcc_vdd_wdata (gen_vec[12]), .gen_nrst_in (gen_vec[11]), .gen_obl_rst (gen_vec[10]),
    .gen_lpwr2_rst (gen_vec[9]), .gen_lpwr1_rst (gen_vec[8]), .gen_wwdg1_out_rst (gen_vec[7]),
    .gen_wwdg2_out_rst (gen_vec[6]), .gen_cpu2_sftrst (gen_vec[5]),
    .gen_cpu1_sftrst (gen_vec[4]), .gen_pwr_por_rst (gen_vec[3]),
    .gen_pwr_bor_rst (gen_vec[2]), .gen_d2_rst (gen_vec[1]), .gen_d1_rst (gen_vec[0])
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // xor pairs of the test-mode loop, output order as func_drv
  function automatic logic [12:0] loop_value(input logic [14:0] a, input logic [14:0] b,
                                             input logic l);
    loop_value = {a[ix_lpwr2] ^ a[ix_lpwr1], a[ix_por] ^ a[ix_pin], a[ix_bor] ^ a[ix_d2],
                  a[ix_d1] ^ a[ix_obl], a[ix_rmv] ^ b[ix_lpwr2], b[ix_lpwr1] ^ b[ix_wwdg2],
                  b[ix_wwdg1] ^ b[ix_iwdg2], b[ix_iwdg1] ^ b[ix_sft2], b[ix_sft1] ^ b[ix_por],
                  b[ix_pin] ^ b[ix_bor], b[ix_d2] ^ b[ix_d1], b[ix_obl] ^ b[ix_rmv], l};
  endfunction

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    lfsr_step = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // taps 16 14 13 11
  endfunction

  task automatic take_bits(input int n, output int val);
    val = 0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr_step(lfsr);
      val  = (val << 1) | int'(lfsr[0]);  // one step per bit
    end
  endtask

  task automatic report_mismatch(input string what, input logic [14:0] exp_v,
                                 input logic [14:0] act_v);
    $display("[ERROR] %s %s: expected %h, actual %h", test_name, what, exp_v, act_v);
    $display("*** TEST FAILED ***");
    $fatal(1, "value mismatch");
  endtask

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1, "run aborted");
  endtask

  // ========================================
  // reference model, sees inputs as they were before the edge
  // ========================================
  always @(posedge clk) begin : ref_model
    logic [12:0] g;
    logic [13:0] lvl;
    logic [13:0] rise;
    logic [14:0] evt;
    if (rst) begin
      m_c1    = '0;
      m_c2    = '0;
      m_lsion = 1'b0;
      m_prev  = '0;
    end else begin
      g      = testmode ? loop_value(m_c1, m_c2, m_lsion) : func_drv;
      lvl    = {iwdg2_rst, iwdg1_rst, g[11:0]};  // source index 0..13
      rise   = lvl & ~m_prev;
      m_prev = lvl;
      evt    = '0;
      evt[ix_por]   = rise[3];
      evt[ix_bor]   = rise[3] | rise[2];
      evt[ix_pin]   = rise[3] | rise[2] | rise[11];
      evt[ix_obl]   = rise[10];
      evt[ix_lpwr1] = rise[8] | rise[9];
      evt[ix_lpwr2] = rise[8] | rise[9];
      evt[ix_wwdg1] = rise[7] | rise[6];
      evt[ix_wwdg2] = rise[7] | rise[6];
      evt[ix_sft1]  = rise[4] | rise[5];
      evt[ix_sft2]  = rise[4] | rise[5];
      evt[ix_d1]    = rise[0] | rise[1];
      evt[ix_d2]    = rise[0] | rise[1];
      evt[ix_iwdg1] = rise[12] | rise[13];
      evt[ix_iwdg2] = rise[12] | rise[13];
      m_c1[14:1] = m_c1[ix_rmv] ? 14'd0 : (m_c1[14:1] | evt[14:1]);  // old rmvf holds clear
      m_c2[14:1] = m_c2[ix_rmv] ? 14'd0 : (m_c2[14:1] | evt[14:1]);
      if (reg_wr && reg_addr == `RCC_VDD_ADDR_C1_RSR) m_c1[ix_rmv] = g[12];
      if (reg_wr && reg_addr == `RCC_VDD_ADDR_C2_RSR) m_c2[ix_rmv] = g[12];
      if (reg_wr && reg_addr == `RCC_VDD_ADDR_CSR)    m_lsion      = g[12];
    end
  end

  // ========================================
  // checks
  // ========================================
  assign exp_gen = testmode ? loop_value(c1_rsr, c2_rsr, csr_lsion) : func_drv;

  always @(negedge clk) begin
    if (!rst) begin
      assert (c1_rsr == m_c1) else report_mismatch("c1_rsr", m_c1, c1_rsr);
      assert (c2_rsr == m_c2) else report_mismatch("c2_rsr", m_c2, c2_rsr);
      assert (csr_lsion == m_lsion)
        else report_mismatch("csr_lsion", {14'd0, m_lsion}, {14'd0, csr_lsion});
      assert (gen_vec == exp_gen)
        else report_mismatch("gen", {2'b00, exp_gen}, {2'b00, gen_vec});
    end
  end

  // registers read zero one cycle after any reset edge
  reset_c1: assert property (@(posedge clk) rst |=> c1_rsr == '0)
    else report_mismatch("c1_rsr after reset", '0, $sampled(c1_rsr));
  reset_c2: assert property (@(posedge clk) rst |=> c2_rsr == '0)
    else report_mismatch("c2_rsr after reset", '0, $sampled(c2_rsr));
  reset_lsion: assert property (@(posedge clk) rst |=> !csr_lsion)
    else report_mismatch("csr_lsion after reset", '0, {14'd0, $sampled(csr_lsion)});

  initial begin
    #(total_cycles * 20 * 2);
    report_failure("timeout, the tests did not finish in the expected time");
  end

  // ========================================
  // stimulus
  // ========================================
  task automatic step(input int n);
    repeat (n) @(posedge clk);
  endtask

  task automatic set_source(input int idx, input logic val);
    if (idx < 12) func_drv[idx] <= val;
    else if (idx == 12) iwdg1_rst <= val;
    else iwdg2_rst <= val;
  endtask

  task automatic write_reg(input logic [1:0] addr, input logic data);
    @(posedge clk);
    reg_wr       <= 1'b1;
    reg_addr     <= addr;
    func_drv[12] <= data;  // data bit goes through the loopback
    @(posedge clk);
    reg_wr       <= 1'b0;
    func_drv[12] <= 1'b0;
  endtask

  task automatic clear_flags();
    write_reg(`RCC_VDD_ADDR_C1_RSR, 1'b1);
    write_reg(`RCC_VDD_ADDR_C2_RSR, 1'b1);
    write_reg(`RCC_VDD_ADDR_C1_RSR, 1'b0);
    write_reg(`RCC_VDD_ADDR_C2_RSR, 1'b0);
  endtask

  initial begin
    int order[14];
    int r;
    int j;
    int tmp;
    rst = 1'b1;
    testmode = 1'b0;
    reg_wr = 1'b0;
    reg_addr = '0;
    func_drv = '0;
    iwdg1_rst = 1'b0;
    iwdg2_rst = 1'b0;
    lfsr = 16'd93;
    test_name = "reset";
    step(5);
    rst <= 1'b0;
    step(2);

    test_name = "pass_through";
    for (int n = 0; n < 20; n++) begin
      take_bits(15, r);
      func_drv  <= r[12:0];
      iwdg1_rst <= r[13];
      iwdg2_rst <= r[14];
      @(posedge clk);
    end
    func_drv  <= '0;
    iwdg1_rst <= 1'b0;
    iwdg2_rst <= 1'b0;
    clear_flags();

    test_name = "event_flags";
    for (int i = 0; i < 14; i++) order[i] = i;
    for (int i = 13; i > 0; i--) begin
      take_bits(4, r);
      j = r % (i + 1);
      tmp = order[i];
      order[i] = order[j];
      order[j] = tmp;
    end
    for (int n = 0; n < 14; n++) begin
      @(posedge clk);
      set_source(order[n], 1'b1);
      step(2);  // level held high, no second event
      @(posedge clk);
      set_source(order[n], 1'b0);
      clear_flags();
    end

    test_name = "removal";
    @(posedge clk);
    take_bits(12, r);
    func_drv[11:0] <= r[11:0] | 12'd1;
    iwdg1_rst      <= 1'b1;  // stays high across the removal
    @(posedge clk);
    func_drv[11:0] <= '0;
    write_reg(`RCC_VDD_ADDR_C1_RSR, 1'b1);
    @(posedge clk);
    take_bits(12, r);
    func_drv[11:0] <= r[11:0] | 12'd2;  // ignored by core 1
    @(posedge clk);
    func_drv[11:0] <= '0;
    write_reg(`RCC_VDD_ADDR_C1_RSR, 1'b0);
    step(2);
    iwdg1_rst <= 1'b0;
    take_bits(12, r);
    func_drv[11:0] <= r[11:0] | 12'd4;
    @(posedge clk);
    func_drv[11:0] <= '0;
    step(2);

    test_name = "csr_write";
    write_reg(`RCC_VDD_ADDR_CSR, 1'b1);
    write_reg(2'd3, 1'b0);  // unmapped
    write_reg(2'd3, 1'b1);
    write_reg(`RCC_VDD_ADDR_CSR, 1'b0);
    write_reg(`RCC_VDD_ADDR_CSR, 1'b1);

    test_name = "loopback";
    @(posedge clk);
    testmode <= 1'b1;
    step(16);
    testmode <= 1'b0;
    clear_flags();
    write_reg(`RCC_VDD_ADDR_CSR, 1'b0);
    @(posedge clk);
    func_drv[3] <= 1'b1;  // por seeds por, bor and pin
    @(posedge clk);
    func_drv[3] <= 1'b0;
    @(posedge clk);
    testmode <= 1'b1;
    step(16);
    testmode <= 1'b0;
    write_reg(`RCC_VDD_ADDR_C1_RSR, 1'b1);  // rmvf high on both cores feeds the loop
    write_reg(`RCC_VDD_ADDR_C2_RSR, 1'b1);
    @(posedge clk);
    testmode <= 1'b1;
    step(4);
    testmode <= 1'b0;
    clear_flags();
    step(2);

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* hdl/rcc_vdd_top.sv */
`default_nettype none

`include "rcc_vdd_config.svh"

module rcc_vdd_top (
  input  wire                        clk,
  input  wire                        rst,
  input  wire                        testmode,
  // ========================================
  // register write
  // ========================================
  input  wire                        reg_wr,
  input  wire [`RCC_VDD_ADDR_W-1:0]  reg_addr,
  // ========================================
  // sources
  // ========================================
  input  wire                        func_rcc_vdd_wdata,
  input  wire                        func_nrst_in,
  input  wire                        func_obl_rst,
  input  wire                        func_lpwr2_rst,
  input  wire                        func_lpwr1_rst,
  input  wire                        func_wwdg1_out_rst,
  input  wire                        func_wwdg2_out_rst,
  input  wire                        func_cpu2_sftrst,
  input  wire                        func_cpu1_sftrst,
  input  wire                        func_pwr_por_rst,
  input  wire                        func_pwr_bor_rst,
  input  wire                        func_d2_rst,
  input  wire                        func_d1_rst,
  input  wire                        iwdg1_rst,           // bypasses the loopback
  input  wire                        iwdg2_rst,
  // ========================================
  // status and observation
  // ========================================
  output wire [`RCC_VDD_RSR_W-1:0]   c1_rsr,              // raw word
  output wire [`RCC_VDD_RSR_W-1:0]   c2_rsr,
  output wire                        csr_lsion,
  output wire                        gen_rcc_vdd_wdata,   // muxed values seen by the regs
  output wire                        gen_nrst_in,
  output wire                        gen_obl_rst,
  output wire                        gen_lpwr2_rst,
  output wire                        gen_lpwr1_rst,
  output wire                        gen_wwdg1_out_rst,
  output wire                        gen_wwdg2_out_rst,
  output wire                        gen_cpu2_sftrst,
  output wire                        gen_cpu1_sftrst,
  output wire                        gen_pwr_por_rst,
  output wire                        gen_pwr_bor_rst,
  output wire                        gen_d2_rst,
  output wire                        gen_d1_rst
);
  import rcc_vdd_pkg::*;

  rsr_word_u c1_rsr_u;  // register output, also fed back
  rsr_word_u c2_rsr_u;

  assign c1_rsr = c1_rsr_u.raw;
  assign c2_rsr = c2_rsr_u.raw;

  rcc_vdd_dft_sig_loopback u_loopback (
    .testmode           (testmode),
    .func_rcc_vdd_wdata (func_rcc_vdd_wdata),
    .func_nrst_in       (func_nrst_in),
    .func_obl_rst       (func_obl_rst),
    .func_lpwr2_rst     (func_lpwr2_rst),
    .func_lpwr1_rst     (func_lpwr1_rst),
    .func_wwdg1_out_rst (func_wwdg1_out_rst),
    .func_wwdg2_out_rst (func_wwdg2_out_rst),
    .func_cpu2_sftrst   (func_cpu2_sftrst),
    .func_cpu1_sftrst   (func_cpu1_sftrst),
    .func_pwr_por_rst   (func_pwr_por_rst),
    .func_pwr_bor_rst   (func_pwr_bor_rst),
    .func_d2_rst        (func_d2_rst),
    .func_d1_rst        (func_d1_rst),
    .c1_rsr             (c1_rsr_u),
    .c2_rsr             (c2_rsr_u),
    .csr_lsion          (csr_lsion),
    .gen_rcc_vdd_wdata  (gen_rcc_vdd_wdata),
    .gen_nrst_in        (gen_nrst_in),
    .gen_obl_rst        (gen_obl_rst),
    .gen_lpwr2_rst      (gen_lpwr2_rst),
    .gen_lpwr1_rst      (gen_lpwr1_rst),
    .gen_wwdg1_out_rst  (gen_wwdg1_out_rst),
    .gen_wwdg2_out_rst  (gen_wwdg2_out_rst),
    .gen_cpu2_sftrst    (gen_cpu2_sftrst),
    .gen_cpu1_sftrst    (gen_cpu1_sftrst),
    .gen_pwr_por_rst    (gen_pwr_por_rst),
    .gen_pwr_bor_rst    (gen_pwr_bor_rst),
    .gen_d2_rst         (gen_d2_rst),
    .gen_d1_rst         (gen_d1_rst)
  );

  rcc_vdd_reg u_reg (
    .clk           (clk),
    .rst           (rst),
    .reg_wr        (reg_wr),
    .reg_addr      (reg_addr),
    .wdata         (gen_rcc_vdd_wdata),  // data bit rides the loopback too
    .nrst_in       (gen_nrst_in),
    .obl_rst       (gen_obl_rst),
    .lpwr2_rst     (gen_lpwr2_rst),
    .lpwr1_rst     (gen_lpwr1_rst),
    .wwdg1_out_rst (gen_wwdg1_out_rst),
    .wwdg2_out_rst (gen_wwdg2_out_rst),
    .cpu2_sftrst   (gen_cpu2_sftrst),
    .cpu1_sftrst   (gen_cpu1_sftrst),
    .pwr_por_rst   (gen_pwr_por_rst),
    .pwr_bor_rst   (gen_pwr_bor_rst),
    .d2_rst        (gen_d2_rst),
    .d1_rst        (gen_d1_rst),
    .iwdg1_rst     (iwdg1_rst),
    .iwdg2_rst     (iwdg2_rst),
    .c1_rsr        (c1_rsr_u),
    .c2_rsr        (c2_rsr_u),
    .csr_lsion     (csr_lsion)
  );

endmodule

`default_nettype wire

/* hdl/rcc_vdd_dft_sig_loopback.sv */
`default_nettype none

module rcc_vdd_dft_sig_loopback (
  input  wire                     testmode,            // 1 selects the xor loop
  // ========================================
  // functional sources
  // ========================================
  input  wire                     func_rcc_vdd_wdata,  // rises low to high, idles 0
  input  wire                     func_nrst_in,
  input  wire                     func_obl_rst,
  input  wire                     func_lpwr2_rst,
  input  wire                     func_lpwr1_rst,
  input  wire                     func_wwdg1_out_rst,
  input  wire                     func_wwdg2_out_rst,
  input  wire                     func_cpu2_sftrst,
  input  wire                     func_cpu1_sftrst,
  input  wire                     func_pwr_por_rst,
  input  wire                     func_pwr_bor_rst,
  input  wire                     func_d2_rst,
  input  wire                     func_d1_rst,
  // ========================================
  // register file readback
  // ========================================
  input  wire rcc_vdd_pkg::rsr_word_u c1_rsr,          // core 1 flags
  input  wire rcc_vdd_pkg::rsr_word_u c2_rsr,          // core 2 flags
  input  wire                     csr_lsion,
  // ========================================
  // muxed sources to the register file
  // ========================================
  output logic                    gen_rcc_vdd_wdata,
  output logic                    gen_nrst_in,
  output logic                    gen_obl_rst,
  output logic                    gen_lpwr2_rst,
  output logic                    gen_lpwr1_rst,
  output logic                    gen_wwdg1_out_rst,
  output logic                    gen_wwdg2_out_rst,
  output logic                    gen_cpu2_sftrst,
  output logic                    gen_cpu1_sftrst,
  output logic                    gen_pwr_por_rst,
  output logic                    gen_pwr_bor_rst,
  output logic                    gen_d2_rst,
  output logic                    gen_d1_rst
);
  import rcc_vdd_pkg::*;

  rsr_word_s   c1;         // field view of core 1
  rsr_word_s   c2;         // field view of core 2
  logic [12:0] func_vec;   // functional values in output order
  logic [12:0] test_vec;   // observation values in output order

  assign c1 = c1_rsr.fld;
  assign c2 = c2_rsr.fld;

  assign func_vec = {func_rcc_vdd_wdata, func_nrst_in, func_obl_rst, func_lpwr2_rst,
                     func_lpwr1_rst, func_wwdg1_out_rst, func_wwdg2_out_rst,
                     func_cpu2_sftrst, func_cpu1_sftrst, func_pwr_por_rst,
                     func_pwr_bor_rst, func_d2_rst, func_d1_rst};

  // xor pairs walk the words so every flag bit reaches some source
  // c1 wwdg, iwdg and sft flags stay out of the loop
  assign test_vec = {c1.lpwr2rstf ^ c1.lpwr1rstf,  // wdata
                     c1.porrstf   ^ c1.pinrstf,    // nrst_in
                     c1.borrstf   ^ c1.d2rstf,     // obl_rst
                     c1.d1rstf    ^ c1.oblrstf,    // lpwr2_rst
                     c1.rmvf      ^ c2.lpwr2rstf,  // lpwr1_rst, crosses cores
                     c2.lpwr1rstf ^ c2.wwdg2rstf,  // wwdg1_out_rst
                     c2.wwdg1rstf ^ c2.iwdg2rstf,  // wwdg2_out_rst
                     c2.iwdg1rstf ^ c2.sft2rstf,   // cpu2_sftrst
                     c2.sft1rstf  ^ c2.porrstf,    // cpu1_sftrst
                     c2.pinrstf   ^ c2.borrstf,    // pwr_por_rst
                     c2.d2rstf    ^ c2.d1rstf,     // pwr_bor_rst
                     c2.oblrstf   ^ c2.rmvf,       // d2_rst
                     csr_lsion};                   // d1_rst

  // one 2:1 mux per line, select shared
  assign {gen_rcc_vdd_wdata, gen_nrst_in, gen_obl_rst, gen_lpwr2_rst,
          gen_lpwr1_rst, gen_wwdg1_out_rst, gen_wwdg2_out_rst,
          gen_cpu2_sftrst, gen_cpu1_sftrst, gen_pwr_por_rst,
          gen_pwr_bor_rst, gen_d2_rst, gen_d1_rst} = testmode ? test_vec : func_vec;

endmodule

`default_nettype wire

/* rcc_vdd_reg/rcc_vdd_reg.sv */
`default_nettype none

`include "rcc_vdd_config.svh"

module rcc_vdd_reg (
  input  wire                        clk,
  input  wire                        rst,
  // ========================================
  // register write
  // ========================================
  input  wire                        reg_wr,         // one cycle strobe
  input  wire [`RCC_VDD_ADDR_W-1:0]  reg_addr,       // valid with reg_wr
  input  wire                        wdata,          // single data bit
  // ========================================
  // reset source levels
  // ========================================
  input  wire                        nrst_in,        // pin reset
  input  wire                        obl_rst,        // option byte load
  input  wire                        lpwr2_rst,
  input  wire                        lpwr1_rst,
  input  wire                        wwdg1_out_rst,
  input  wire                        wwdg2_out_rst,
  input  wire                        cpu2_sftrst,
  input  wire                        cpu1_sftrst,
  input  wire                        pwr_por_rst,    // por from pwr block
  input  wire                        pwr_bor_rst,    // bor from pwr block
  input  wire                        d2_rst,
  input  wire                        d1_rst,
  input  wire                        iwdg1_rst,      // no loopback path
  input  wire                        iwdg2_rst,      // no loopback path
  // ========================================
  // register outputs
  // ========================================
  output rcc_vdd_pkg::rsr_word_u     c1_rsr,
  output rcc_vdd_pkg::rsr_word_u     c2_rsr,
  output logic                       csr_lsion
);
  import rcc_vdd_pkg::*;

  logic [13:0]                src_lvl;   // sampled as one vector
  logic [13:0]                src_q;     // previous edge sample
  logic                       rise_por, rise_bor, rise_nrst, rise_obl, rise_lpwr1, rise_lpwr2;
  logic                       rise_wwdg1, rise_wwdg2, rise_sft1, rise_sft2;
  logic                       rise_d1, rise_d2, rise_iwdg1, rise_iwdg2;
  rsr_word_s                  evt;       // events placed on flag positions
  logic [`RCC_VDD_FLAG_W-1:0] src_evt;   // shared by both cores
  logic                       wr_c1;
  logic                       wr_c2;
  logic                       wr_csr;

  assign src_lvl = {pwr_por_rst, pwr_bor_rst, nrst_in, obl_rst, lpwr1_rst, lpwr2_rst,
                    wwdg1_out_rst, wwdg2_out_rst, cpu1_sftrst, cpu2_sftrst,
                    d1_rst, d2_rst, iwdg1_rst, iwdg2_rst};

  always_ff @(posedge clk) begin
    if (rst) begin
      src_q <= '0;       // a level already high after reset counts as a rise
    end else begin
      src_q <= src_lvl;
    end
  end

  assign {rise_por, rise_bor, rise_nrst, rise_obl, rise_lpwr1, rise_lpwr2,
          rise_wwdg1, rise_wwdg2, rise_sft1, rise_sft2,
          rise_d1, rise_d2, rise_iwdg1, rise_iwdg2} = src_lvl & ~src_q;

  // ========================================
  // flag map
  // ========================================
  always_comb begin
    evt           = '0;
    evt.porrstf   = rise_por;
    evt.borrstf   = rise_por | rise_bor;              // por implies bor
    evt.pinrstf   = rise_por | rise_bor | rise_nrst;  // every supply reset pulls the pin
    evt.oblrstf   = rise_obl;
    evt.lpwr1rstf = rise_lpwr1 | rise_lpwr2;          // paired flags set together
    evt.lpwr2rstf = rise_lpwr1 | rise_lpwr2;
    evt.wwdg1rstf = rise_wwdg1 | rise_wwdg2;
    evt.wwdg2rstf = rise_wwdg1 | rise_wwdg2;
    evt.sft1rstf  = rise_sft1 | rise_sft2;
    evt.sft2rstf  = rise_sft1 | rise_sft2;
    evt.d1rstf    = rise_d1 | rise_d2;
    evt.d2rstf    = rise_d1 | rise_d2;
    evt.iwdg1rstf = rise_iwdg1 | rise_iwdg2;
    evt.iwdg2rstf = rise_iwdg1 | rise_iwdg2;
  end

  assign src_evt = evt[`RCC_VDD_RSR_W-1:1];  // rmvf slot never carries an event

  // write decode, code 3 selects nothing
  assign wr_c1  = reg_wr & (reg_addr == `RCC_VDD_ADDR_C1_RSR);
  assign wr_c2  = reg_wr & (reg_addr == `RCC_VDD_ADDR_C2_RSR);
  assign wr_csr = reg_wr & (reg_addr == `RCC_VDD_ADDR_CSR);

  always_ff @(posedge clk) begin
    if (rst) begin
      csr_lsion <= 1'b0;
    end else if (wr_csr) begin
      csr_lsion <= wdata;  // lsi enable
    end
  end

  // ========================================
  // per core status
  // ========================================
  rcc_vdd_rsr u_c1_rsr (
    .clk      (clk),
    .rst      (rst),
    .src_evt  (src_evt),
    .rmv_wr   (wr_c1),
    .rmv_data (wdata),
    .rsr      (c1_rsr)
  );

  rcc_vdd_rsr u_c2_rsr (
    .clk      (clk),
    .rst      (rst),
    .src_evt  (src_evt),
    .rmv_wr   (wr_c2),
    .rmv_data (wdata),
    .rsr      (c2_rsr)
  );

endmodule

`default_nettype wire

/* rcc_vdd_reg/rcc_vdd_rsr.sv */
`default_nettype none

`include "rcc_vdd_config.svh"

// reset status register of one core
module rcc_vdd_rsr (
  input  wire                         clk,
  input  wire                         rst,
  // ========================================
  // event side
  // ========================================
  input  wire [`RCC_VDD_FLAG_W-1:0]   src_evt,   // one cycle pulses, field order, no rmvf
  // ========================================
  // register write side
  // ========================================
  input  wire                         rmv_wr,    // write strobe for this rsr
  input  wire                         rmv_data,  // new rmvf value
  output rcc_vdd_pkg::rsr_word_u      rsr        // flags and rmvf
);
  import rcc_vdd_pkg::*;

  rsr_word_u                  rsr_q;      // registered word
  logic [`RCC_VDD_FLAG_W-1:0] flags_cur;  // current flags only
  logic [`RCC_VDD_FLAG_W-1:0] flags_nxt;  // next flag state

  assign flags_cur = rsr_q.raw[`RCC_VDD_RSR_W-1:1];  // drop rmvf

  // ========================================
  // next state of the flags
  // ========================================
  always_comb begin
    if (rsr_q.fld.rmvf) begin
      flags_nxt = '0;                  // removal active, hold clear and drop events
    end else begin
      flags_nxt = flags_cur | src_evt;  // sticky set
    end
  end

  // ========================================
  // state
  // ========================================
  always_ff @(posedge clk) begin
    if (rst) begin
      rsr_q.raw <= '0;                             // all flags and rmvf low
    end else begin
      rsr_q.raw[`RCC_VDD_RSR_W-1:1] <= flags_nxt;  // flags every cycle
      if (rmv_wr) begin
        rsr_q.fld.rmvf <= rmv_data;                // clear takes hold on the next edge
      end
    end
  end

  assign rsr = rsr_q;  // straight from the flops

endmodule

`default_nettype wire

/* common/rcc_vdd_pkg.sv */
`default_nettype none

`include "rcc_vdd_config.svh"

package rcc_vdd_pkg;

  // ========================================
  // reset status word, msb first
  // ========================================
  typedef struct packed {
    logic lpwr2rstf;  // low power reset, domain 2
    logic lpwr1rstf;  // low power reset, domain 1
    logic wwdg2rstf;  // window watchdog 2
    logic wwdg1rstf;  // window watchdog 1
    logic iwdg2rstf;  // independent watchdog 2
    logic iwdg1rstf;  // independent watchdog 1
    logic sft2rstf;   // cpu2 software reset
    logic sft1rstf;   // cpu1 software reset
    logic porrstf;    // power on reset
    logic pinrstf;    // nrst pin
    logic borrstf;    // brown out reset
    logic d2rstf;     // d2 domain reset
    logic d1rstf;     // d1 domain reset
    logic oblrstf;    // option byte load reset
    logic rmvf;       // remove flags, write 1 to clear
  } rsr_word_s;

  // same word seen as named flags or as plain bits
  typedef union packed {
    rsr_word_s                 fld;  // per flag view
    logic [`RCC_VDD_RSR_W-1:0] raw;  // bus view
  } rsr_word_u;

endpackage

`default_nettype wire

/* common/rcc_vdd_config.svh */
`ifndef RCC_VDD_CONFIG_SVH
`define RCC_VDD_CONFIG_SVH

// ========================================
// register select
// ========================================

// width of reg_addr
`define RCC_VDD_ADDR_W 2

// core 1 reset status register
`define RCC_VDD_ADDR_C1_RSR 2'd0
// core 2 reset status register
`define RCC_VDD_ADDR_C2_RSR 2'd1
// csr, only lsion lives in this domain
`define RCC_VDD_ADDR_CSR 2'd2

// ========================================
// reset status word
// ========================================

// 14 reset flags plus rmvf
`define RCC_VDD_RSR_W 15
// flag part of the word without rmvf
`define RCC_VDD_FLAG_W (`RCC_VDD_RSR_W - 1)

`endif
